// ==== dcore_pkg.sv ====
`default_nettype none

package dcore_pkg;

    // checker operating mode
    typedef enum logic [1:0] {
        PRBS_IDLE  = 2'd0,
        PRBS_CHECK = 2'd1,
        PRBS_CLEAR = 2'd2
    } prbs_mode_e;

    // APB register map, byte addresses
    typedef enum logic [7:0] {
        REG_CTRL       = 8'h00,
        REG_NAVG       = 8'h04,
        REG_EXT_OFFSET = 8'h08,
        REG_CAL_DONE   = 8'h0C,
        REG_PRBS_TOTAL = 8'h10,
        REG_PRBS_ERR   = 8'h14,
        // per-slice offsets follow at 4-byte steps
        REG_OFFSET0    = 8'h20
    } dcore_reg_e;

    // PRBS7 feedback taps, x^7 + x^6 + 1
    localparam int PRBS_TAP_A = 7;
    localparam int PRBS_TAP_B = 6;

endpackage

`default_nettype wire

// ==== ti_adc_retimer.sv ====
`default_nettype none

module ti_adc_retimer #(
    parameter int n_ti  = 4,
    parameter int n_adc = 7
) (
    input  wire logic                  clk_adc,
    input  wire logic                  arst_n_i,
    input  wire logic [n_ti*n_adc-1:0] in_data_i,
    input  wire logic [n_ti-1:0]       in_sign_i,
    output logic      [n_ti*n_adc-1:0] out_data_o,
    output logic      [n_ti-1:0]       out_sign_o
);
    localparam int n_lo = n_ti / 2;

    // early-phase slices, caught mid-cycle
    logic [n_lo*n_adc-1:0] lo_data_neg;
    logic [n_lo-1:0]       lo_sign_neg;
    // first rising-edge stage, one sample across all slices
    logic [n_ti*n_adc-1:0] stg1_data;
    logic [n_ti-1:0]       stg1_sign;

    always_ff @(negedge clk_adc or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lo_data_neg <= '0;
            lo_sign_neg <= '0;
        end else begin
            lo_data_neg <= in_data_i[n_lo*n_adc-1:0];
            lo_sign_neg <= in_sign_i[n_lo-1:0];
        end
    end

    always_ff @(posedge clk_adc or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stg1_data  <= '0;
            stg1_sign  <= '0;
            out_data_o <= '0;
            out_sign_o <= '0;
        end else begin
            // upper half straight from the pins, lower half from the falling edge
            stg1_data  <= {in_data_i[n_ti*n_adc-1:n_lo*n_adc], lo_data_neg};
            stg1_sign  <= {in_sign_i[n_ti-1:n_lo], lo_sign_neg};
            out_data_o <= stg1_data;
            out_sign_o <= stg1_sign;
        end
    end

endmodule

`default_nettype wire

// ==== adc_unfolding.sv ====
`default_nettype none

module adc_unfolding #(
    parameter int n_adc = 7
) (
    input  wire logic                  clk_adc,
    input  wire logic                  arst_n_i,
    input  wire logic [n_adc-1:0]      din_i,
    input  wire logic                  sign_i,
    input  wire logic                  en_cal_i,
    input  wire logic                  en_ext_offset_i,
    input  wire logic signed [n_adc:0] ext_offset_i,
    input  wire logic [3:0]            navg_i,
    output logic signed [n_adc:0]      dout_o,
    output logic signed [n_adc:0]      offset_o,
    output logic                       cal_done_o
);
    localparam int cw       = n_adc + 1;
    // room for up to 2^15 summed codes
    localparam int acc_w    = cw + 15;
    localparam int code_max = 2**(cw-1) - 1;
    localparam int code_min = -(2**(cw-1));

    typedef enum logic [1:0] {
        CAL_IDLE,
        CAL_ACC,
        CAL_DONE
    } cal_state_e;

    cal_state_e              state;
    logic [15:0]             n_samp;
    logic [15:0]             last_samp;
    logic signed [acc_w-1:0] acc;
    logic signed [acc_w-1:0] avg;
    logic signed [cw-1:0]    offset_meas;
    logic signed [cw-1:0]    raw_code;
    logic signed [cw:0]      diff;

    // sign bit set means a positive code
    assign raw_code  = sign_i ? $signed({1'b0, din_i}) : -$signed({1'b0, din_i});
    assign last_samp = (16'd1 << navg_i) - 16'd1;
    assign avg       = acc >>> navg_i;
    assign offset_o  = en_ext_offset_i ? ext_offset_i : offset_meas;
    // one extra bit so the subtraction cannot wrap
    assign diff      = raw_code - offset_o;

    always_ff @(posedge clk_adc or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state       <= CAL_IDLE;
            n_samp      <= '0;
            acc         <= '0;
            offset_meas <= '0;
            cal_done_o  <= 1'b0;
        end else if (!en_cal_i) begin
            state      <= CAL_IDLE;
            cal_done_o <= 1'b0;
        end else begin
            case (state)
                CAL_IDLE: begin
                    // en_cal just went high, start a fresh sum
                    state  <= CAL_ACC;
                    n_samp <= '0;
                    acc    <= '0;
                end
                CAL_ACC: begin
                    acc    <= acc + raw_code;
                    n_samp <= n_samp + 16'd1;
                    if (n_samp == last_samp) begin
                        state <= CAL_DONE;
                    end
                end
                CAL_DONE: begin
                    // latch once, then hold until en_cal drops
                    if (!cal_done_o) begin
                        offset_meas <= avg[cw-1:0];
                        cal_done_o  <= 1'b1;
                    end
                end
                default: begin
                    state <= CAL_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_adc or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dout_o <= '0;
        end else if (diff > code_max) begin
            dout_o <= cw'(code_max);
        end else if (diff < code_min) begin
            dout_o <= cw'(code_min);
        end else begin
            dout_o <= diff[cw-1:0];
        end
    end

    a_cal_done_drops: assert property (
        @(posedge clk_adc) disable iff (!arst_n_i)
        !en_cal_i |=> !cal_done_o
    );

endmodule

`default_nettype wire

// ==== prbs_checker.sv ====
`default_nettype none

module prbs_checker #(
    parameter int n_ch = 4
) (
    input  wire logic                  clk_adc,
    input  wire logic                  arst_n_i,
    input  wire logic [n_ch-1:0]       rx_bits_i,
    input  wire dcore_pkg::prbs_mode_e mode_i,
    output logic [31:0]                total_bits_o,
    output logic [31:0]                err_bits_o
);
    import dcore_pkg::*;

    localparam int hist_w = PRBS_TAP_A;
    localparam int cnt_w  = $clog2(n_ch + 1);

    logic [hist_w-1:0]      hist;
    logic [n_ch+hist_w-1:0] seq;
    logic [n_ch-1:0]        err_vec;
    logic [cnt_w-1:0]       n_err;
    logic [32:0]            total_sum;
    logic [32:0]            err_sum;

    // history in the low bits, current word above it, oldest bit at index 0
    assign seq = {rx_bits_i, hist};

    always_comb begin
        n_err = '0;
        for (int k = 0; k < n_ch; k++) begin
            // prediction from the bits 7 and 6 places earlier
            err_vec[k] = rx_bits_i[k]
                       ^ seq[k + hist_w - PRBS_TAP_A]
                       ^ seq[k + hist_w - PRBS_TAP_B];
            n_err = n_err + cnt_w'(err_vec[k]);
        end
    end

    assign total_sum = {1'b0, total_bits_o} + 33'(n_ch);
    assign err_sum   = {1'b0, err_bits_o} + 33'(n_err);

    always_ff @(posedge clk_adc or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hist         <= '0;
            total_bits_o <= '0;
            err_bits_o   <= '0;
        end else begin
            // history runs in every mode
            hist <= seq[n_ch +: hist_w];
            if (mode_i == PRBS_CHECK) begin
                // saturate at all ones
                total_bits_o <= total_sum[32] ? '1 : total_sum[31:0];
                err_bits_o   <= err_sum[32] ? '1 : err_sum[31:0];
            end else if (mode_i == PRBS_CLEAR) begin
                total_bits_o <= '0;
                err_bits_o   <= '0;
            end
        end
    end

    a_cnt_no_decrease: assert property (
        @(posedge clk_adc) disable iff (!arst_n_i)
        mode_i != PRBS_CLEAR |=>
            (total_bits_o >= $past(total_bits_o)) && (err_bits_o >= $past(err_bits_o))
    );

endmodule

`default_nettype wire

// ==== dcore_regs.sv ====
`default_nettype none

module dcore_regs #(
    parameter int n_ti  = 4,
    parameter int n_adc = 7
) (
    input  wire logic                      clk_adc,
    input  wire logic                      arst_n_i,
    input  wire logic                      psel_i,
    input  wire logic                      penable_i,
    input  wire logic                      pwrite_i,
    input  wire logic [7:0]                paddr_i,
    input  wire logic [31:0]               pwdata_i,
    output logic      [31:0]               prdata_o,
    output logic                           pready_o,
    output logic                           pslverr_o,
    output logic                           en_cal_o,
    output logic                           en_ext_offset_o,
    output logic signed [n_adc:0]          ext_offset_o,
    output logic      [3:0]                navg_o,
    output dcore_pkg::prbs_mode_e          prbs_mode_o,
    input  wire logic [n_ti*(n_adc+1)-1:0] offset_i,
    input  wire logic [n_ti-1:0]           cal_done_i,
    input  wire logic [31:0]               total_bits_i,
    input  wire logic [31:0]               err_bits_i
);
    import dcore_pkg::*;

    localparam int cw = n_adc + 1;

    logic       setup;
    logic       access;
    logic       addr_err;
    logic       read_only;
    logic [7:0] off_addr;

    assign setup  = psel_i && !penable_i;
    assign access = psel_i && penable_i;

    // address decode and read mux
    always_comb begin
        off_addr  = paddr_i - 8'(REG_OFFSET0);
        addr_err  = 1'b0;
        read_only = 1'b1;
        prdata_o  = '0;
        case (paddr_i)
            REG_CTRL: begin
                read_only = 1'b0;
                prdata_o  = {28'd0, prbs_mode_o, en_ext_offset_o, en_cal_o};
            end
            REG_NAVG: begin
                read_only = 1'b0;
                prdata_o  = {28'd0, navg_o};
            end
            REG_EXT_OFFSET: begin
                read_only = 1'b0;
                prdata_o  = 32'(ext_offset_o);
            end
            REG_CAL_DONE:   prdata_o = 32'(cal_done_i);
            REG_PRBS_TOTAL: prdata_o = total_bits_i;
            REG_PRBS_ERR:   prdata_o = err_bits_i;
            default: begin
                // offset readback window, one word per slice
                if (paddr_i >= REG_OFFSET0 && off_addr[1:0] == 2'b00
                        && off_addr[7:2] < n_ti) begin
                    prdata_o = 32'($signed(offset_i[off_addr[7:2]*cw +: cw]));
                end else begin
                    addr_err = 1'b1;
                end
            end
        endcase
    end

    always_ff @(posedge clk_adc or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pready_o        <= 1'b0;
            pslverr_o       <= 1'b0;
            en_cal_o        <= 1'b0;
            en_ext_offset_o <= 1'b0;
            ext_offset_o    <= '0;
            navg_o          <= '0;
            prbs_mode_o     <= PRBS_IDLE;
        end else begin
            // response decided in setup, presented in the access phase
            pready_o  <= setup;
            pslverr_o <= setup && (addr_err || (pwrite_i && read_only));
            if (access && pwrite_i && !addr_err && !read_only) begin
                if (paddr_i == REG_CTRL) begin
                    en_cal_o        <= pwdata_i[0];
                    en_ext_offset_o <= pwdata_i[1];
                    prbs_mode_o     <= prbs_mode_e'(pwdata_i[3:2]);
                end else if (paddr_i == REG_NAVG) begin
                    navg_o <= pwdata_i[3:0];
                end else if (paddr_i == REG_EXT_OFFSET) begin
                    ext_offset_o <= pwdata_i[cw-1:0];
                end
            end
        end
    end

    // zero wait states with a master that always follows setup by access
    a_pready_access: assert property (
        @(posedge clk_adc) disable iff (!arst_n_i)
        pready_o == (psel_i && penable_i)
    );

    a_pslverr_in_access: assert property (
        @(posedge clk_adc) disable iff (!arst_n_i)
        pslverr_o |-> (pready_o && psel_i && penable_i)
    );

endmodule

`default_nettype wire

// ==== digital_core.sv ====
`default_nettype none

module digital_core #(
    parameter int n_ti  = 4,
    parameter int n_adc = 7
) (
    input  wire logic                      clk_adc,
    input  wire logic                      arst_n_i,
    input  wire logic [n_ti*n_adc-1:0]     adc_data_i,
    input  wire logic [n_ti-1:0]           adc_sign_i,
    output wire logic [n_ti*(n_adc+1)-1:0] dout_o,
    input  wire logic                      psel_i,
    input  wire logic                      penable_i,
    input  wire logic                      pwrite_i,
    input  wire logic [7:0]                paddr_i,
    input  wire logic [31:0]               pwdata_i,
    output wire logic [31:0]               prdata_o,
    output wire logic                      pready_o,
    output wire logic                      pslverr_o
);
    import dcore_pkg::*;

    localparam int cw = n_adc + 1;

    wire logic [n_ti*n_adc-1:0] data_rt;
    wire logic [n_ti-1:0]       sign_rt;
    wire logic [n_ti*cw-1:0]    offset;
    wire logic [n_ti-1:0]       cal_done;
    wire logic [n_ti-1:0]       prbs_rx_bits;
    wire logic                  en_cal;
    wire logic                  en_ext_offset;
    wire logic signed [cw-1:0]  ext_offset;
    wire logic [3:0]            navg;
    wire prbs_mode_e            prbs_mode;
    wire logic [31:0]           total_bits;
    wire logic [31:0]           err_bits;

    ti_adc_retimer #(.n_ti(n_ti), .n_adc(n_adc)) retimer_i (
        .clk_adc   (clk_adc),
        .arst_n_i  (arst_n_i),
        .in_data_i (adc_data_i),
        .in_sign_i (adc_sign_i),
        .out_data_o(data_rt),
        .out_sign_o(sign_rt)
    );

    for (genvar k = 0; k < n_ti; k++) begin : g_slice
        adc_unfolding #(.n_adc(n_adc)) unfold_i (
            .clk_adc        (clk_adc),
            .arst_n_i       (arst_n_i),
            .din_i          (data_rt[k*n_adc +: n_adc]),
            .sign_i         (sign_rt[k]),
            .en_cal_i       (en_cal),
            .en_ext_offset_i(en_ext_offset),
            .ext_offset_i   (ext_offset),
            .navg_i         (navg),
            .dout_o         (dout_o[k*cw +: cw]),
            .offset_o       (offset[k*cw +: cw]),
            .cal_done_o     (cal_done[k])
        );

        // decision is 1 for a positive code
        assign prbs_rx_bits[k] = ~dout_o[k*cw + cw - 1];
    end

    prbs_checker #(.n_ch(n_ti)) prbs_checker_i (
        .clk_adc     (clk_adc),
        .arst_n_i    (arst_n_i),
        .rx_bits_i   (prbs_rx_bits),
        .mode_i      (prbs_mode),
        .total_bits_o(total_bits),
        .err_bits_o  (err_bits)
    );

    dcore_regs #(.n_ti(n_ti), .n_adc(n_adc)) regs_i (
        .clk_adc        (clk_adc),
        .arst_n_i       (arst_n_i),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .prdata_o       (prdata_o),
        .pready_o       (pready_o),
        .pslverr_o      (pslverr_o),
        .en_cal_o       (en_cal),
        .en_ext_offset_o(en_ext_offset),
        .ext_offset_o   (ext_offset),
        .navg_o         (navg),
        .prbs_mode_o    (prbs_mode),
        .offset_i       (offset),
        .cal_done_i     (cal_done),
        .total_bits_i   (total_bits),
        .err_bits_i     (err_bits)
    );

endmodule

`default_nettype wire

// ==== tb_digital_core.sv ====
`default_nettype none

module tb_digital_core;
    import dcore_pkg::*;

    localparam int n_ti    = 4;
    localparam int n_adc   = 7;
    localparam int cw      = n_adc + 1;
    localparam int period  = 40;
    // registers, external offset, calibration, two PRBS runs
    localparam int test_cycles = 80 + 100 + 200 + 2 * 100;
    localparam int margin      = 200;

    logic                  clk_adc;
    logic                  arst_n;
    logic [n_ti*n_adc-1:0] adc_data;
    logic [n_ti-1:0]       adc_sign;
    logic [n_ti*cw-1:0]    dout;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [7:0]            paddr;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;

    logic [31:0] lfsr_state = 32'h887d;
    logic [6:0]  prbs_state = 7'h7f;
    logic        prbs_run   = 1'b0;
    int          prbs_cyc   = 0;
    int          flip_cyc   = -1;

    digital_core #(.n_ti(n_ti), .n_adc(n_adc)) DUT (
        .clk_adc   (clk_adc),
        .arst_n_i  (arst_n),
        .adc_data_i(adc_data),
        .adc_sign_i(adc_sign),
        .dout_o    (dout),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    initial begin
        clk_adc = 1'b0;
        forever #(period / 2) clk_adc = ~clk_adc;
    end

    initial begin
        #((test_cycles + margin) * period);
        $display("Timeout: the tests did not complete in time");
        $display("Finished with errors");
        $fatal(1);
    end

    // 32-bit Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val        = {val[30:0], fb};
        end
        return val;
    endfunction

    // PRBS7 reference, b[n] = b[n-7] ^ b[n-6]
    function automatic logic prbs_next();
        logic nb;
        nb         = prbs_state[6] ^ prbs_state[5];
        prbs_state = {prbs_state[5:0], nb};
        return nb;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("Fail at time %0t: %s, got %h expected %h", $time, msg, got, exp);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge clk_adc);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk_adc);
        penable <= 1'b1;
        @(negedge clk_adc);
        check(32'(pready), 32'd1, "pready in write access");
        err = pslverr;
        @(posedge clk_adc);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk_adc);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk_adc);
        penable <= 1'b1;
        @(negedge clk_adc);
        check(32'(pready), 32'd1, "pready in read access");
        data = prdata;
        err  = pslverr;
        @(posedge clk_adc);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_ok(input logic [7:0] addr, input logic [31:0] data);
        logic err;
        apb_write(addr, data, err);
        check(32'(err), 32'd0, "pslverr on valid write");
    endtask

    task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp,
                               input string msg);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check(32'(err), 32'd0, "pslverr on valid read");
        check(data, exp, msg);
    endtask

    task automatic probe_registers();
        logic [31:0] data;
        logic        err;
        read_expect(REG_CTRL, 32'd0, "CTRL after reset");
        read_expect(REG_NAVG, 32'd0, "NAVG after reset");
        read_expect(REG_EXT_OFFSET, 32'd0, "EXT_OFFSET after reset");
        read_expect(REG_CAL_DONE, 32'd0, "CAL_DONE after reset");
        read_expect(REG_PRBS_TOTAL, 32'd0, "PRBS_TOTAL after reset");
        read_expect(REG_PRBS_ERR, 32'd0, "PRBS_ERR after reset");
        for (int k = 0; k < n_ti; k++) begin
            read_expect(8'(REG_OFFSET0 + 4 * k), 32'd0, "OFFSET after reset");
        end
        write_ok(REG_CTRL, 32'h0000_000a);
        read_expect(REG_CTRL, 32'h0000_000a, "CTRL readback");
        write_ok(REG_CTRL, 32'd0);
        write_ok(REG_NAVG, 32'd5);
        read_expect(REG_NAVG, 32'd5, "NAVG readback");
        write_ok(REG_EXT_OFFSET, 32'hffff_ff9c);
        read_expect(REG_EXT_OFFSET, 32'hffff_ff9c, "EXT_OFFSET readback");
        apb_write(REG_PRBS_ERR, 32'h1234, err);
        check(32'(err), 32'd1, "pslverr on read-only write");
        read_expect(REG_PRBS_ERR, 32'd0, "PRBS_ERR unchanged");
        apb_read(8'h18, data, err);
        check(32'(err), 32'd1, "pslverr on undefined address");
        apb_read(8'(REG_OFFSET0 + 4 * n_ti), data, err);
        check(32'(err), 32'd1, "pslverr on offset index out of range");
    endtask

    task automatic sweep_ext_offset(input int offset);
        int exp_q[$];
        int raw;
        int exp;
        write_ok(REG_EXT_OFFSET, 32'(offset));
        write_ok(REG_CTRL, 32'h2);
        for (int i = 0; i < 40 + 3; i++) begin
            @(posedge clk_adc);
            if (i < 40) begin
                for (int k = 0; k < n_ti; k++) begin
                    // every eighth sample at full scale to hit saturation
                    adc_data[k*n_adc +: n_adc] <= (i % 8 == 0) ? 7'h7f : 7'(lfsr_bits(n_adc));
                    adc_sign[k] <= (i % 16 == 0) ? offset < 0 : lfsr_bits(1);
                end
            end
            @(negedge clk_adc);
            if (i < 40) begin
                for (int k = 0; k < n_ti; k++) begin
                    raw = adc_sign[k] ? int'(adc_data[k*n_adc +: n_adc])
                                      : -int'(adc_data[k*n_adc +: n_adc]);
                    exp = raw - offset;
                    exp = (exp > 127) ? 127 : (exp < -128) ? -128 : exp;
                    exp_q.push_back(exp);
                end
            end
            if (i >= 3) begin
                for (int k = 0; k < n_ti; k++) begin
                    check(32'($signed(dout[k*cw +: cw])), 32'(exp_q.pop_front()),
                          "dout with external offset");
                end
            end
        end
        write_ok(REG_CTRL, 32'h0);
    endtask

    task automatic calibrate_offsets();
        int          level[n_ti] = '{5, -2, 0, 7};
        logic [31:0] data;
        logic        err;
        int          polls;
        @(posedge clk_adc);
        for (int k = 0; k < n_ti; k++) begin
            adc_data[k*n_adc +: n_adc] <= 7'(level[k] < 0 ? -level[k] : level[k]);
            adc_sign[k] <= level[k] >= 0;
        end
        write_ok(REG_NAVG, 32'd3);
        write_ok(REG_CTRL, 32'h1);
        polls = 0;
        data  = '0;
        while (data[n_ti-1:0] != '1 && polls < 40) begin
            apb_read(REG_CAL_DONE, data, err);
            polls++;
        end
        check(data, 32'(4'hf), "CAL_DONE all slices");
        for (int k = 0; k < n_ti; k++) begin
            read_expect(8'(REG_OFFSET0 + 4 * k), 32'(level[k]), "measured offset");
        end
        @(negedge clk_adc);
        for (int k = 0; k < n_ti; k++) begin
            check(32'($signed(dout[k*cw +: cw])), 32'd0, "dout after calibration");
        end
        write_ok(REG_CTRL, 32'h0);
        read_expect(REG_CAL_DONE, 32'd0, "CAL_DONE cleared");
    endtask

    // PRBS stream driver, runs beside the bus tasks
    initial begin
        forever begin
            @(posedge clk_adc);
            if (prbs_run) begin
                for (int k = 0; k < n_ti; k++) begin
                    adc_sign[k] <= prbs_next() ^ (prbs_cyc == flip_cyc && k == 1);
                    adc_data[k*n_adc +: n_adc] <= 7'(lfsr_bits(n_adc)) | 7'h1;
                end
                prbs_cyc <= prbs_cyc + 1;
            end
        end
    end

    task automatic count_prbs_errors(input logic flip, input int exp_err);
        write_ok(REG_EXT_OFFSET, 32'd0);
        prbs_run = 1'b1;
        repeat (10) @(posedge clk_adc);
        write_ok(REG_CTRL, 32'h0000_000a);
        write_ok(REG_CTRL, 32'h0000_0006);
        if (flip) begin
            flip_cyc = prbs_cyc + 20;
        end
        // 47 idle edges plus 3 for the next write give 50 counted cycles
        repeat (47) @(posedge clk_adc);
        write_ok(REG_CTRL, 32'h0000_0002);
        read_expect(REG_PRBS_TOTAL, 32'(50 * n_ti), "PRBS total bits");
        read_expect(REG_PRBS_ERR, 32'(exp_err), "PRBS error bits");
    endtask

    initial begin
        arst_n   = 1'b0;
        adc_data = '0;
        adc_sign = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        repeat (5) @(posedge clk_adc);
        arst_n <= 1'b1;
        probe_registers();
        sweep_ext_offset(-100);
        sweep_ext_offset(100);
        calibrate_offsets();
        count_prbs_errors(1'b0, 0);
        // one flipped bit shows up three times in the prediction
        count_prbs_errors(1'b1, 3);
        write_ok(REG_CTRL, 32'h0000_000a);
        read_expect(REG_PRBS_TOTAL, 32'd0, "PRBS total after clear");
        read_expect(REG_PRBS_ERR, 32'd0, "PRBS errors after clear");
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
dcore_pkg.sv
ti_adc_retimer.sv
adc_unfolding.sv
prbs_checker.sv
dcore_regs.sv
digital_core.sv
tb_digital_core.sv
